// File: logic/swap_pkg.sv
// Swap lock package
// Shared widths, memory depth, request opcodes and the state encodings
// of the bus endpoint and the swap controller.

package swap_pkg;

    // ------------------------------------------------------------------------
    // widths and sizes
    // ------------------------------------------------------------------------

    // data word width
    localparam int DATA_W = 32;

    // word address width
    localparam int ADDR_W = 8;

    // one enable per byte lane
    localparam int MASK_W = DATA_W / 8;

    // number of memory words
    localparam int MEM_DEPTH = 256;

    // each of x and y
    localparam int CORD_W = 4;

    // ------------------------------------------------------------------------
    // encodings
    // ------------------------------------------------------------------------

    // request opcode carried with every endpoint request
    typedef enum logic [1:0] {
        OP_NORMAL  = 2'd0,
        OP_ACQUIRE = 2'd1,
        OP_RELEASE = 2'd2
    } swap_op_e;

    // swap controller, store phase follows an accepted swap
    typedef enum logic [1:0] {
        SWAP_IDLE    = 2'd0,
        SWAP_STORING = 2'd1
    } swap_state_e;

    // bus endpoint
    typedef enum logic [1:0] {
        EP_IDLE = 2'd0,
        EP_WAIT = 2'd1,
        EP_ACK  = 2'd2
    } ep_state_e;

endpackage

// File: logic/ep_req_if.sv
// Endpoint request channel
// Valid/yumi handshake with word address, data, byte mask, write flag,
// swap opcode and the source coordinates of the requester.

`timescale 1ns/1ps

interface ep_req_if import swap_pkg::*; ();

    logic              v;
    logic              yumi;
    logic [DATA_W-1:0] data;
    logic [MASK_W-1:0] mask;
    logic [ADDR_W-1:0] addr;
    logic              we;
    swap_op_e          op;
    logic [CORD_W-1:0] x_cord;
    logic [CORD_W-1:0] y_cord;

    // request source
    modport master (
        output v, data, mask, addr, we, op, x_cord, y_cord,
        input  yumi
    );

    // request sink, yumi only while v is high
    modport slave (
        input  v, data, mask, addr, we, op, x_cord, y_cord,
        output yumi
    );

endinterface

// File: logic/mem_req_if.sv
// Memory request channel
// No back-pressure, so every cycle with v high is a transfer.

`timescale 1ns/1ps

interface mem_req_if import swap_pkg::*; ();

    logic              v;
    logic [DATA_W-1:0] data;
    logic [MASK_W-1:0] mask;
    logic [ADDR_W-1:0] addr;
    logic              we;

    modport master (
        output v, data, mask, addr, we
    );

    modport slave (
        input  v, data, mask, addr, we
    );

endinterface

// File: logic/local_mem.sv
// Local data memory
// Word addressed array with per-byte write enables. Every request gets
// rvalid one cycle later, with the word as it was before any write.

`timescale 1ns/1ps

module local_mem import swap_pkg::*; (
    input  logic              clk_i,
    mem_req_if.slave          mem_i,
    output logic [DATA_W-1:0] rdata_o,
    output logic              rvalid_o
);

    logic [DATA_W-1:0] mem_r [MEM_DEPTH];

    // byte-enable write port
    always_ff @(posedge clk_i) begin
        if (mem_i.v && mem_i.we) begin
            for (int b = 0; b < MASK_W; b++) begin
                if (mem_i.mask[b]) begin
                    mem_r[mem_i.addr][8*b +: 8] <= mem_i.data[8*b +: 8];
                end
            end
        end
    end

    // old word returned for reads and writes alike
    always_ff @(posedge clk_i) begin
        if (mem_i.v) begin
            rdata_o <= mem_r[mem_i.addr];
        end
    end

    // one response a cycle after each accepted request
    always_ff @(posedge clk_i) begin
        rvalid_o <= mem_i.v;
    end

endmodule

// File: logic/swap_ctrl.sv
// Atomic swap lock controller
// Holds a single lock and its owner record. Normal requests pass straight
// to the memory; a successful acquire or release reads the old word and
// stores the new data one cycle later. Failed swaps skip the memory and
// return their own write data.

`timescale 1ns/1ps

module swap_ctrl import swap_pkg::*; (
    input  logic              clk_i,
    input  logic              reset_i,

    // request from the bus endpoint
    ep_req_if.slave           ep_i,

    // request to the local memory
    mem_req_if.master         mem_o,

    // memory response
    input  logic [DATA_W-1:0] mem_rdata_i,
    input  logic              mem_rvalid_i,

    // merged response to the endpoint
    output logic [DATA_W-1:0] ep_rdata_o,
    output logic              ep_rvalid_o
);

    swap_state_e       state_r;
    swap_state_e       state_n;

    // lock and owner record
    logic              lock_r;
    logic [ADDR_W-1:0] owner_addr_r;
    logic [CORD_W-1:0] owner_x_r;
    logic [CORD_W-1:0] owner_y_r;
    logic [DATA_W-1:0] swap_data_r;
    logic [MASK_W-1:0] swap_mask_r;

    // response merging
    logic              fail_r;
    logic [DATA_W-1:0] fail_data_r;
    logic              store_r;

    logic idle;
    logic storing;
    logic take;
    logic is_normal;
    logic is_aq;
    logic is_rl;
    logic owner_match;
    logic aq_ok;
    logic aq_fail;
    logic rl_ok;
    logic rl_fail;
    logic swap_ok;
    logic swap_fail;

    // ------------------------------------------------------------------------
    // swap decision
    // ------------------------------------------------------------------------

    assign idle    = (state_r == SWAP_IDLE);
    assign storing = (state_r == SWAP_STORING);

    // requests are only taken while idle
    assign take = ep_i.v && idle;

    assign is_normal = (ep_i.op == OP_NORMAL);
    assign is_aq     = (ep_i.op == OP_ACQUIRE);
    assign is_rl     = (ep_i.op == OP_RELEASE);

    assign owner_match = (ep_i.addr == owner_addr_r)
                      && (ep_i.x_cord == owner_x_r)
                      && (ep_i.y_cord == owner_y_r);

    assign aq_ok   = take && is_aq && !lock_r;
    assign aq_fail = take && is_aq && lock_r;
    assign rl_ok   = take && is_rl && lock_r && owner_match;
    assign rl_fail = take && is_rl && !(lock_r && owner_match);

    assign swap_ok   = aq_ok || rl_ok;
    assign swap_fail = aq_fail || rl_fail;

    assign ep_i.yumi = take;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            lock_r <= 1'b0;
        end else if (aq_ok) begin
            lock_r <= 1'b1;
        end else if (rl_ok) begin
            lock_r <= 1'b0;
        end
    end

    // owner fields and the data for the store phase
    always_ff @(posedge clk_i) begin
        if (swap_ok) begin
            owner_addr_r <= ep_i.addr;
            owner_x_r    <= ep_i.x_cord;
            owner_y_r    <= ep_i.y_cord;
            swap_data_r  <= ep_i.data;
            swap_mask_r  <= ep_i.mask;
        end
    end

    // ------------------------------------------------------------------------
    // read-then-write sequencing
    // ------------------------------------------------------------------------

    always_comb begin
        case (state_r)
            SWAP_IDLE:    state_n = swap_ok ? SWAP_STORING : SWAP_IDLE;
            // memory never stalls, so the store takes one cycle
            SWAP_STORING: state_n = SWAP_IDLE;
            default:      state_n = SWAP_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_r <= SWAP_IDLE;
        end else begin
            state_r <= state_n;
        end
    end

    // read phase uses the live request, store phase the owner record
    assign mem_o.v    = storing || (take && !swap_fail);
    assign mem_o.we   = storing || (is_normal && ep_i.we);
    assign mem_o.data = storing ? swap_data_r : ep_i.data;
    assign mem_o.mask = storing ? swap_mask_r : ep_i.mask;
    assign mem_o.addr = storing ? owner_addr_r : ep_i.addr;

    // ------------------------------------------------------------------------
    // response merging
    // ------------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            fail_r  <= 1'b0;
            store_r <= 1'b0;
        end else begin
            fail_r  <= swap_fail;
            store_r <= storing;
        end
    end

    always_ff @(posedge clk_i) begin
        fail_data_r <= ep_i.data;
    end

    // the store response has no requester waiting for it
    assign ep_rvalid_o = fail_r || (mem_rvalid_i && !store_r);
    assign ep_rdata_o  = fail_r ? fail_data_r : mem_rdata_i;

endmodule

// File: logic/wb_endpoint.sv
// Wishbone classic slave endpoint
// Samples a new bus cycle, raises one endpoint request for it, waits for
// the response, registers the returned word and gives a one-cycle ack.
// Opcode and source coordinates come from the address and cycle tags.

`timescale 1ns/1ps

module wb_endpoint import swap_pkg::*; (
    input  logic              clk_i,
    input  logic              reset_i,

    // wishbone slave side
    input  logic              wb_cyc_i,
    input  logic              wb_stb_i,
    input  logic              wb_we_i,
    input  logic [ADDR_W-1:0] wb_adr_i,
    input  logic [DATA_W-1:0] wb_dat_i,
    input  logic [MASK_W-1:0] wb_sel_i,
    input  swap_op_e          wb_tga_op_i,
    input  logic [CORD_W-1:0] wb_tgc_x_i,
    input  logic [CORD_W-1:0] wb_tgc_y_i,
    output logic              wb_ack_o,
    output logic [DATA_W-1:0] wb_dat_o,

    // request toward the swap controller
    ep_req_if.master          ep_o,

    // response from the swap controller
    input  logic [DATA_W-1:0] ep_rdata_i,
    input  logic              ep_rvalid_i
);

    ep_state_e         state_r;
    logic              req_v_r;
    logic [DATA_W-1:0] rdata_r;

    // ------------------------------------------------------------------------
    // bus cycle FSM
    // ------------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_r <= EP_IDLE;
            req_v_r <= 1'b0;
        end else begin
            case (state_r)
                EP_IDLE: begin
                    if (wb_cyc_i && wb_stb_i) begin
                        state_r <= EP_WAIT;
                        req_v_r <= 1'b1;
                    end
                end
                EP_WAIT: begin
                    // request leaves on yumi, response comes a cycle later
                    if (ep_o.yumi) begin
                        req_v_r <= 1'b0;
                    end
                    if (ep_rvalid_i) begin
                        state_r <= EP_ACK;
                    end
                end
                EP_ACK: begin
                    state_r <= EP_IDLE;
                end
                default: begin
                    state_r <= EP_IDLE;
                    req_v_r <= 1'b0;
                end
            endcase
        end
    end

    // hold the returned word for the ack cycle
    always_ff @(posedge clk_i) begin
        if (state_r == EP_WAIT && ep_rvalid_i) begin
            rdata_r <= ep_rdata_i;
        end
    end

    // ------------------------------------------------------------------------
    // outputs
    // ------------------------------------------------------------------------

    // master holds the bus fields until ack, so they feed the request as is
    assign ep_o.v      = req_v_r;
    assign ep_o.data   = wb_dat_i;
    assign ep_o.mask   = wb_sel_i;
    assign ep_o.addr   = wb_adr_i;
    assign ep_o.we     = wb_we_i;
    assign ep_o.op     = wb_tga_op_i;
    assign ep_o.x_cord = wb_tgc_x_i;
    assign ep_o.y_cord = wb_tgc_y_i;

    assign wb_ack_o = (state_r == EP_ACK);
    assign wb_dat_o = rdata_r;

endmodule

// File: logic/tile_mem_top.sv
// Tile memory top level
// Wishbone slave port in front of the swap lock controller and the
// local data memory.

`timescale 1ns/1ps

module tile_mem_top import swap_pkg::*; (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              wb_cyc_i,
    input  logic              wb_stb_i,
    input  logic              wb_we_i,
    input  logic [ADDR_W-1:0] wb_adr_i,
    input  logic [DATA_W-1:0] wb_dat_i,
    input  logic [MASK_W-1:0] wb_sel_i,
    input  swap_op_e          wb_tga_op_i,
    input  logic [CORD_W-1:0] wb_tgc_x_i,
    input  logic [CORD_W-1:0] wb_tgc_y_i,
    output logic              wb_ack_o,
    output logic [DATA_W-1:0] wb_dat_o
);

    ep_req_if  ep_if ();
    mem_req_if mem_if ();

    // response path
    logic [DATA_W-1:0] mem_rdata;
    logic              mem_rvalid;
    logic [DATA_W-1:0] ep_rdata;
    logic              ep_rvalid;

    wb_endpoint i_wb_endpoint (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_sel_i    (wb_sel_i),
        .wb_tga_op_i (wb_tga_op_i),
        .wb_tgc_x_i  (wb_tgc_x_i),
        .wb_tgc_y_i  (wb_tgc_y_i),
        .wb_ack_o    (wb_ack_o),
        .wb_dat_o    (wb_dat_o),
        .ep_o        (ep_if.master),
        .ep_rdata_i  (ep_rdata),
        .ep_rvalid_i (ep_rvalid)
    );

    swap_ctrl i_swap_ctrl (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .ep_i         (ep_if.slave),
        .mem_o        (mem_if.master),
        .mem_rdata_i  (mem_rdata),
        .mem_rvalid_i (mem_rvalid),
        .ep_rdata_o   (ep_rdata),
        .ep_rvalid_o  (ep_rvalid)
    );

    local_mem i_local_mem (
        .clk_i    (clk_i),
        .mem_i    (mem_if.slave),
        .rdata_o  (mem_rdata),
        .rvalid_o (mem_rvalid)
    );

endmodule

// File: sim/tile_mem_asserts.sv
// Tile memory assertions
// Handshake and timing properties, bound into the endpoint and the
// swap controller.

`timescale 1ns/1ps

module tile_mem_asserts (
    input logic clk_i,
    input logic reset_i,
    input logic yumi_i,
    input logic v_i,
    input logic ack_i,
    input logic fail_i,
    input logic mem_v_i
);

    // request is only taken while it is offered
    a_yumi_v : assert property (@(posedge clk_i) disable iff (reset_i) yumi_i |-> v_i)
        else $error("yumi high without v");

    a_ack_once : assert property (@(posedge clk_i) disable iff (reset_i) ack_i |=> !ack_i)
        else $error("wb ack longer than one cycle");

    // failed swap has no store phase
    a_fail_quiet : assert property (@(posedge clk_i) disable iff (reset_i) fail_i |=> !mem_v_i)
        else $error("memory request after a failed swap");

endmodule

bind swap_ctrl tile_mem_asserts i_ctrl_asserts (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .yumi_i  (ep_i.yumi),
    .v_i     (ep_i.v),
    .ack_i   (1'b0),
    .fail_i  (swap_fail),
    .mem_v_i (mem_o.v)
);

bind wb_endpoint tile_mem_asserts i_ep_asserts (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .yumi_i  (ep_o.yumi),
    .v_i     (ep_o.v),
    .ack_i   (wb_ack_o),
    .fail_i  (1'b0),
    .mem_v_i (1'b0)
);

// File: sim/tb_tile_mem.sv
// Testbench for the tile memory with swap lock
// Drives Wishbone cycles, predicts every response with a reference model
// and checks the returned word and the ack latency.

`timescale 1ns/1ps

module tb_tile_mem import swap_pkg::*; ();

    logic              clk_i;
    logic              reset_i;
    logic              wb_cyc_i;
    logic              wb_stb_i;
    logic              wb_we_i;
    logic [ADDR_W-1:0] wb_adr_i;
    logic [DATA_W-1:0] wb_dat_i;
    logic [MASK_W-1:0] wb_sel_i;
    swap_op_e          wb_tga_op_i;
    logic [CORD_W-1:0] wb_tgc_x_i;
    logic [CORD_W-1:0] wb_tgc_y_i;
    logic              wb_ack_o;
    logic [DATA_W-1:0] wb_dat_o;

    // reference model of the memory and the lock
    logic [DATA_W-1:0] model_mem [MEM_DEPTH];
    // words whose contents are fully known
    bit                model_vld [MEM_DEPTH];
    bit                lock_held;
    logic [ADDR_W-1:0] own_addr;
    logic [CORD_W-1:0] own_x;
    logic [CORD_W-1:0] own_y;

    logic [DATA_W-1:0] exp_data_q [$];
    bit                exp_chk_q [$];
    logic [DATA_W-1:0] act_data_q [$];
    integer            act_lat_q [$];

    integer            seed;
    integer            err_cnt;
    integer            chk_cnt;
    bit                timed_out;
    logic [31:0]       rnd;
    swap_op_e          rop;

    tile_mem_top i_dut (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_sel_i    (wb_sel_i),
        .wb_tga_op_i (wb_tga_op_i),
        .wb_tgc_x_i  (wb_tgc_x_i),
        .wb_tgc_y_i  (wb_tgc_y_i),
        .wb_ack_o    (wb_ack_o),
        .wb_dat_o    (wb_dat_o)
    );

    always #4 clk_i = ~clk_i;

    // ------------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------------

    function automatic logic [DATA_W-1:0] ref_access(
        input  swap_op_e          op,
        input  logic              we,
        input  logic [ADDR_W-1:0] addr,
        input  logic [CORD_W-1:0] x,
        input  logic [CORD_W-1:0] y,
        input  logic [DATA_W-1:0] data,
        input  logic [MASK_W-1:0] mask,
        output bit                chk
    );
        logic [DATA_W-1:0] result;
        bit                store;
        result = model_mem[addr];
        chk    = model_vld[addr];
        store  = 1'b0;
        case (op)
            OP_ACQUIRE: begin
                if (!lock_held) begin
                    store     = 1'b1;
                    lock_held = 1'b1;
                    own_addr  = addr;
                    own_x     = x;
                    own_y     = y;
                end else begin
                    result = data;
                    chk    = 1'b1;
                end
            end
            OP_RELEASE: begin
                if (lock_held && addr == own_addr && x == own_x && y == own_y) begin
                    store     = 1'b1;
                    lock_held = 1'b0;
                end else begin
                    result = data;
                    chk    = 1'b1;
                end
            end
            default: store = we;
        endcase
        if (store) begin
            for (int b = 0; b < MASK_W; b++) begin
                if (mask[b]) begin
                    model_mem[addr][8*b +: 8] = data[8*b +: 8];
                end
            end
            if (&mask) begin
                model_vld[addr] = 1'b1;
            end
        end
        return result;
    endfunction

    function automatic logic [DATA_W-1:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic [MASK_W-1:0] rand_mask();
        return MASK_W'($random(seed));
    endfunction

    function automatic logic [ADDR_W-1:0] rand_addr(input integer span);
        return ADDR_W'($unsigned($random(seed)) % span);
    endfunction

    // ------------------------------------------------------------------------
    // checks and end of run
    // ------------------------------------------------------------------------

    task automatic check_data(input string name, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_latency(input string name, input integer got, input integer exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("checks %0d, errors %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    // one bus cycle with ack sampled at the falling edge
    task automatic wb_access(input swap_op_e op, input logic we,
                             input logic [ADDR_W-1:0] addr,
                             input logic [CORD_W-1:0] x, input logic [CORD_W-1:0] y,
                             input logic [DATA_W-1:0] data, input logic [MASK_W-1:0] mask);
        logic [DATA_W-1:0] exp;
        bit                chk;
        integer            edges;
        bit                ack_seen;
        if (timed_out) begin
            return;
        end
        exp = ref_access(op, we, addr, x, y, data, mask, chk);
        exp_data_q.push_back(exp);
        exp_chk_q.push_back(chk);
        wb_cyc_i    = 1'b1;
        wb_stb_i    = 1'b1;
        wb_we_i     = we;
        wb_adr_i    = addr;
        wb_dat_i    = data;
        wb_sel_i    = mask;
        wb_tga_op_i = op;
        wb_tgc_x_i  = x;
        wb_tgc_y_i  = y;
        edges       = 0;
        ack_seen    = 1'b0;
        while (!ack_seen && edges < 20) begin
            @(posedge clk_i);
            edges++;
            @(negedge clk_i);
            ack_seen = wb_ack_o;
        end
        if (!ack_seen) begin
            err_cnt++;
            timed_out = 1'b1;
            $display("no wb_ack_o within 20 cycles for the bus cycle at %h", addr);
        end else begin
            act_data_q.push_back(wb_dat_o);
            act_lat_q.push_back(edges);
            @(posedge clk_i);
            #1;
            wb_cyc_i = 1'b0;
            wb_stb_i = 1'b0;
        end
    endtask

    // compare acked responses against the predictions
    always @(posedge clk_i) begin
        logic [DATA_W-1:0] got;
        logic [DATA_W-1:0] exp;
        bit                chk;
        integer            lat;
        while (act_data_q.size() > 0 && exp_data_q.size() > 0) begin
            got = act_data_q.pop_front();
            lat = act_lat_q.pop_front();
            exp = exp_data_q.pop_front();
            chk = exp_chk_q.pop_front();
            if (chk) begin
                check_data("wb_dat_o", got, exp);
            end
            // ack sampled three edges after cyc and stb
            check_latency("wb_ack_o latency", lat, 3);
        end
    end

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------

    initial begin
        seed        = 45;
        err_cnt     = 0;
        chk_cnt     = 0;
        timed_out   = 1'b0;
        lock_held   = 1'b0;
        clk_i       = 1'b0;
        reset_i     = 1'b1;
        wb_cyc_i    = 1'b0;
        wb_stb_i    = 1'b0;
        wb_we_i     = 1'b0;
        wb_adr_i    = '0;
        wb_dat_i    = '0;
        wb_sel_i    = '0;
        wb_tga_op_i = OP_NORMAL;
        wb_tgc_x_i  = '0;
        wb_tgc_y_i  = '0;
        repeat (2) @(posedge clk_i);
        #1;
        reset_i = 1'b0;

        // known contents for the whole address set
        for (int a = 0; a < 16; a++) begin
            wb_access(OP_NORMAL, 1'b1, ADDR_W'(a), 4'd1, 4'd2, rand_word(), '1);
        end

        // masked writes with a read-back after each
        for (int i = 0; i < 16; i++) begin
            wb_adr_i = rand_addr(16);
            wb_access(OP_NORMAL, 1'b1, wb_adr_i, 4'd1, 4'd2, rand_word(), rand_mask());
            wb_access(OP_NORMAL, 1'b0, wb_adr_i, 4'd1, 4'd2, rand_word(), '0);
        end

        // acquire, held-lock acquire, bad releases, good release, reacquire
        wb_access(OP_ACQUIRE, 1'b1, 8'd5, 4'd1, 4'd2, rand_word(), rand_mask());
        wb_access(OP_NORMAL, 1'b0, 8'd5, 4'd1, 4'd2, '0, '0);
        wb_access(OP_ACQUIRE, 1'b1, 8'd6, 4'd3, 4'd4, rand_word(), '1);
        wb_access(OP_NORMAL, 1'b0, 8'd6, 4'd1, 4'd2, '0, '0);
        wb_access(OP_RELEASE, 1'b1, 8'd7, 4'd1, 4'd2, rand_word(), '1);
        wb_access(OP_RELEASE, 1'b1, 8'd5, 4'd3, 4'd4, rand_word(), '1);
        wb_access(OP_NORMAL, 1'b0, 8'd5, 4'd1, 4'd2, '0, '0);
        wb_access(OP_NORMAL, 1'b0, 8'd7, 4'd1, 4'd2, '0, '0);
        wb_access(OP_RELEASE, 1'b1, 8'd5, 4'd1, 4'd2, rand_word(), '1);
        wb_access(OP_NORMAL, 1'b0, 8'd5, 4'd1, 4'd2, '0, '0);
        wb_access(OP_ACQUIRE, 1'b1, 8'd9, 4'd3, 4'd4, rand_word(), rand_mask());
        wb_access(OP_NORMAL, 1'b0, 8'd9, 4'd1, 4'd2, '0, '0);
        wb_access(OP_RELEASE, 1'b1, 8'd9, 4'd3, 4'd4, rand_word(), '1);
        wb_access(OP_RELEASE, 1'b1, 8'd9, 4'd1, 4'd2, rand_word(), '1);
        wb_access(OP_NORMAL, 1'b0, 8'd9, 4'd1, 4'd2, '0, '0);

        // random mix on a small address set with two requesters
        for (int i = 0; i < 200; i++) begin
            rop = swap_op_e'(2'($unsigned($random(seed)) % 3));
            rnd = $random(seed);
            if (rnd[0]) begin
                wb_access(rop, rnd[1], rand_addr(8), 4'd1, 4'd2, rand_word(), rand_mask());
            end else begin
                wb_access(rop, rnd[1], rand_addr(8), 4'd3, 4'd4, rand_word(), rand_mask());
            end
        end

        finish_run();
    end

endmodule

// File: src.f
logic/swap_pkg.sv
logic/ep_req_if.sv
logic/mem_req_if.sv
logic/local_mem.sv
logic/swap_ctrl.sv
logic/wb_endpoint.sv
logic/tile_mem_top.sv
sim/tile_mem_asserts.sv
sim/tb_tile_mem.sv

// File: run.sh
#!/bin/sh
# compile and run the tile memory testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_tile_mem -f src.f

out=$(./obj_dir/Vtb_tile_mem) || true
echo "$out"

if echo "$out" | grep -qx "Result: PASSED"; then
    exit 0
fi
exit 1
